//--- all.f
+incdir+.
ecc_pkg.sv
ecc_37_codec.sv
ecc_word_store.sv
ecc_error_log.sv
ecc_mem_top.sv
tb_ecc_mem.sv

//--- ecc_37_codec.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_37_codec (
    input  ecc_pkg::ecc_data_t  data_in,
    input  ecc_pkg::ecc_check_t parity_in,
    input  logic                bypass,
    output ecc_pkg::ecc_data_t  data_out,
    output ecc_pkg::ecc_check_t parity_out,
    output logic                sbit_err,
    output logic                dbit_err
);
    import ecc_pkg::*;

    ecc_check_t syndrome;
    ecc_data_t  mask;
    logic       single_err;
    logic       double_err;

    assign parity_out = ecc_parity(data_in);    // parity of the word as it was read.
    assign syndrome   = parity_in ^ parity_out;

    always_comb begin
        mask       = '0;
        single_err = 1'b1;
        double_err = 1'b0;
        case (syndrome)
            7'h00: single_err = 1'b0;   // clean word.
            7'h43: mask[0]  = 1'b1;
            7'h45: mask[1]  = 1'b1;
            7'h46: mask[2]  = 1'b1;
            7'h07: mask[3]  = 1'b1;
            7'h49: mask[4]  = 1'b1;
            7'h4A: mask[5]  = 1'b1;
            7'h0B: mask[6]  = 1'b1;
            7'h4C: mask[7]  = 1'b1;
            7'h0D: mask[8]  = 1'b1;
            7'h0E: mask[9]  = 1'b1;
            7'h4F: mask[10] = 1'b1;
            7'h51: mask[11] = 1'b1;
            7'h52: mask[12] = 1'b1;
            7'h13: mask[13] = 1'b1;
            7'h54: mask[14] = 1'b1;
            7'h15: mask[15] = 1'b1;
            7'h16: mask[16] = 1'b1;
            7'h57: mask[17] = 1'b1;
            7'h58: mask[18] = 1'b1;
            7'h19: mask[19] = 1'b1;
            7'h1A: mask[20] = 1'b1;
            7'h5B: mask[21] = 1'b1;
            7'h1C: mask[22] = 1'b1;
            7'h5D: mask[23] = 1'b1;
            7'h5E: mask[24] = 1'b1;
            7'h1F: mask[25] = 1'b1;
            7'h61: mask[26] = 1'b1;
            7'h62: mask[27] = 1'b1;
            7'h23: mask[28] = 1'b1;
            7'h64: mask[29] = 1'b1;
            7'h25: mask[30] = 1'b1;
            7'h26: mask[31] = 1'b1;
            7'h67: mask[32] = 1'b1;
            7'h68: mask[33] = 1'b1;
            7'h29: mask[34] = 1'b1;
            7'h2A: mask[35] = 1'b1;
            7'h6B: mask[36] = 1'b1;
            7'h40, 7'h20, 7'h10, 7'h08, 7'h04, 7'h02, 7'h01: begin
                mask = '0;  // a check bit flipped, the data is intact.
            end
            default: begin
                single_err = 1'b0;  // even weight, so two bits flipped.
                double_err = 1'b1;
            end
        endcase
    end

    // Bypass hands the raw stored word through for fault inspection.
    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && single_err;
    assign dbit_err = !bypass && double_err;

endmodule

`default_nettype wire

//--- ecc_error_log.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_error_log (
    input  logic                clk,
    input  logic                reset,
    input  logic                rd_valid,
    input  logic                sbit_err,
    input  logic                dbit_err,
    input  ecc_pkg::ecc_addr_t  rd_addr_q,
    input  logic                log_clear,
    output ecc_pkg::ecc_count_t sbit_count,
    output ecc_pkg::ecc_count_t dbit_count,
    output ecc_pkg::ecc_addr_t  last_err_addr
);

    logic flagged;

    assign flagged = rd_valid && (sbit_err || dbit_err);

    always_ff @(posedge clk) begin
        if (reset || log_clear) begin
            sbit_count    <= '0;
            dbit_count    <= '0;
            last_err_addr <= '0;
        end else begin
            if (rd_valid && sbit_err && !(&sbit_count)) begin
                sbit_count <= sbit_count + 1'b1;    // holds once all ones.
            end
            if (rd_valid && dbit_err && !(&dbit_count)) begin
                dbit_count <= dbit_count + 1'b1;
            end
            if (flagged) begin
                last_err_addr <= rd_addr_q;
            end
        end
    end

    counts_monotonic: assert property (@(posedge clk) disable iff (reset)
        !log_clear |=> (sbit_count >= $past(sbit_count)) &&
                       (dbit_count >= $past(dbit_count)));

endmodule

`default_nettype wire

//--- ecc_mem_top.sv
`timescale 1ns/100ps
`default_nettype none

module ecc_mem_top (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_en,
    input  ecc_pkg::ecc_addr_t  wr_addr,
    input  ecc_pkg::ecc_data_t  wr_data,
    input  ecc_pkg::ecc_data_t  inject_data,
    input  ecc_pkg::ecc_check_t inject_check,
    input  logic                rd_en,
    input  ecc_pkg::ecc_addr_t  rd_addr,
    input  logic                bypass,
    output ecc_pkg::ecc_data_t  rd_data,
    output logic                rd_valid,
    output logic                sbit_err,
    output logic                dbit_err,
    input  logic                log_clear,
    output ecc_pkg::ecc_count_t sbit_count,
    output ecc_pkg::ecc_count_t dbit_count,
    output ecc_pkg::ecc_addr_t  last_err_addr
);
    import ecc_pkg::*;

    ecc_data_t  stored_data;
    ecc_check_t stored_check;
    ecc_addr_t  rd_addr_q;

    ecc_word_store u_store (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .inject_data  (inject_data),
        .inject_check (inject_check),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .stored_data  (stored_data),
        .stored_check (stored_check),
        .rd_valid     (rd_valid),
        .rd_addr_q    (rd_addr_q)
    );

    // decode happens in the cycle the registered word is valid.
    ecc_37_codec u_codec (
        .data_in    (stored_data),
        .parity_in  (stored_check),
        .bypass     (bypass),
        .data_out   (rd_data),
        .parity_out (),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    ecc_error_log u_log (
        .clk           (clk),
        .reset         (reset),
        .rd_valid      (rd_valid),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .rd_addr_q     (rd_addr_q),
        .log_clear     (log_clear),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

endmodule

`default_nettype wire

//--- ecc_pkg.sv
`default_nettype none

`include "ecc_settings.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]  ecc_data_t;
    typedef logic [`ECC_CHECK_WIDTH-1:0] ecc_check_t;   // check word and syndrome.
    typedef logic [`ECC_ADDR_WIDTH-1:0]  ecc_addr_t;
    typedef logic [`ECC_COUNT_WIDTH-1:0] ecc_count_t;

    // Each check bit is the even parity of the data columns selected by its row mask.
    // Data columns all have odd weight, so single and double errors stay apart.
    function automatic ecc_check_t ecc_parity(input ecc_data_t d);
        ecc_check_t p;
        p[0] = ^(d & 37'h1556AAAD5B);
        p[1] = ^(d & 37'h199B33366D);
        p[2] = ^(d & 37'h01E3C3C78E);
        p[3] = ^(d & 37'h1E03FC07F0);
        p[4] = ^(d & 37'h0003FFF800);   // columns 11 to 25.
        p[5] = ^(d & 37'h1FFC000000);   // columns 26 to 36.
        p[6] = ^(d & 37'h132DA65CB7);
        return p;
    endfunction

endpackage

`default_nettype wire

//--- ecc_settings.svh
`ifndef ECC_SETTINGS_SVH
`define ECC_SETTINGS_SVH

// payload and check bits of one protected word.
`define ECC_DATA_WIDTH  37
`define ECC_CHECK_WIDTH 7

// the word array is fully decoded, so depth is 2**addr width.
`define ECC_ADDR_WIDTH  6
`define ECC_MEM_DEPTH   64

`define ECC_COUNT_WIDTH 16

`endif

//--- ecc_word_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "ecc_settings.svh"

module ecc_word_store (
    input  logic                clk,
    input  logic                reset,
    input  logic                wr_en,
    input  ecc_pkg::ecc_addr_t  wr_addr,
    input  ecc_pkg::ecc_data_t  wr_data,
    input  ecc_pkg::ecc_data_t  inject_data,
    input  ecc_pkg::ecc_check_t inject_check,
    input  logic                rd_en,
    input  ecc_pkg::ecc_addr_t  rd_addr,
    output ecc_pkg::ecc_data_t  stored_data,
    output ecc_pkg::ecc_check_t stored_check,
    output logic                rd_valid,
    output ecc_pkg::ecc_addr_t  rd_addr_q
);
    import ecc_pkg::*;

    ecc_data_t  data_mem  [`ECC_MEM_DEPTH];
    ecc_check_t check_mem [`ECC_MEM_DEPTH];

    // check bits come from the clean data, so the masks model faults in the array.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_addr]  <= wr_data ^ inject_data;
            check_mem[wr_addr] <= ecc_parity(wr_data) ^ inject_check;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            stored_data  <= data_mem[rd_addr];
            stored_check <= check_mem[rd_addr];
            rd_addr_q    <= rd_addr;    // kept for the error log.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    wr_addr_known: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown(wr_addr));

    rd_addr_known: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> !$isunknown(rd_addr));

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Builds and runs the ECC memory testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_ecc_mem -f all.f -o tb_ecc_mem_sim

./obj_dir/tb_ecc_mem_sim | tee sim.log

if grep -qx "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb_ecc_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "ecc_settings.svh"

module tb_ecc_mem;
    import ecc_pkg::*;

    localparam int CLK_PERIOD     = 4;
    localparam int RESET_CYCLES   = 4;
    localparam int NUM_SINGLE     = 16;
    localparam int NUM_DOUBLE     = 16;
    localparam int NUM_BYPASS     = 4;
    localparam int READ_TIMEOUT   = 8;
    localparam int FLIP_POSITIONS = `ECC_DATA_WIDTH + `ECC_CHECK_WIDTH;
    localparam int NUM_CASES      = `ECC_MEM_DEPTH + NUM_SINGLE + `ECC_CHECK_WIDTH
                                    + NUM_DOUBLE + NUM_BYPASS;
    localparam int TEST_CYCLES    = RESET_CYCLES + NUM_CASES * 5 + 20; // a write and a read.
    localparam int MARGIN_CYCLES  = 200;

    // syndrome of each data column, read off the check matrix.
    localparam ecc_check_t COLUMN [`ECC_DATA_WIDTH] = '{
        7'h43, 7'h45, 7'h46, 7'h07, 7'h49, 7'h4A, 7'h0B, 7'h4C, 7'h0D, 7'h0E,
        7'h4F, 7'h51, 7'h52, 7'h13, 7'h54, 7'h15, 7'h16, 7'h57, 7'h58, 7'h19,
        7'h1A, 7'h5B, 7'h1C, 7'h5D, 7'h5E, 7'h1F, 7'h61, 7'h62, 7'h23, 7'h64,
        7'h25, 7'h26, 7'h67, 7'h68, 7'h29, 7'h2A, 7'h6B
    };

    logic       clk = 1'b0;
    logic       reset;
    logic       wr_en;
    ecc_addr_t  wr_addr;
    ecc_data_t  wr_data;
    ecc_data_t  inject_data;
    ecc_check_t inject_check;
    logic       rd_en;
    ecc_addr_t  rd_addr;
    logic       bypass;
    ecc_data_t  rd_data;
    logic       rd_valid;
    logic       sbit_err;
    logic       dbit_err;
    logic       log_clear;
    ecc_count_t sbit_count;
    ecc_count_t dbit_count;
    ecc_addr_t  last_err_addr;

    ecc_count_t exp_sbit_count;
    ecc_count_t exp_dbit_count;
    ecc_addr_t  exp_last_addr;
    ecc_data_t  written [`ECC_MEM_DEPTH];

    ecc_mem_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .inject_data   (inject_data),
        .inject_check  (inject_check),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .bypass        (bypass),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .sbit_err      (sbit_err),
        .dbit_err      (dbit_err),
        .log_clear     (log_clear),
        .sbit_count    (sbit_count),
        .dbit_count    (dbit_count),
        .last_err_addr (last_err_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic ecc_check_t model_check(input ecc_data_t d);
        ecc_check_t c;
        c = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                c = c ^ COLUMN[i];
            end
        end
        return c;
    endfunction

    function automatic ecc_data_t random_word();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[`ECC_DATA_WIDTH-1:0];
    endfunction

    function automatic ecc_addr_t random_addr();
        return ecc_addr_t'($urandom_range(`ECC_MEM_DEPTH - 1, 0));
    endfunction

    function automatic int pick_other_position(input int taken);
        int pos;
        pos = taken;
        while (pos == taken) begin
            pos = $urandom_range(FLIP_POSITIONS - 1, 0);
        end
        return pos;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_data(input string name, input ecc_data_t got, input ecc_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_code(input string name, input ecc_check_t got, input ecc_check_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input ecc_count_t got, input ecc_count_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_addr(input string name, input ecc_addr_t got, input ecc_addr_t exp);
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic add_flip(input int pos, inout ecc_data_t inj_d, inout ecc_check_t inj_c);
        if (pos < `ECC_DATA_WIDTH) begin
            inj_d[pos] = 1'b1;
        end else begin
            inj_c[pos - `ECC_DATA_WIDTH] = 1'b1;   // positions above the data are check bits.
        end
    endtask

    task automatic write_word(input ecc_addr_t addr, input ecc_data_t data,
                              input ecc_data_t inj_d, input ecc_check_t inj_c);
        @(posedge clk);
        wr_en        <= 1'b1;
        wr_addr      <= addr;
        wr_data      <= data;
        inject_data  <= inj_d;
        inject_check <= inj_c;
        @(posedge clk);
        wr_en        <= 1'b0;
        inject_data  <= '0;
        inject_check <= '0;
    endtask

    task automatic read_and_check(input ecc_addr_t addr, input logic byp,
                                  input ecc_data_t exp_data, input ecc_check_t exp_code,
                                  input logic exp_sbit, input logic exp_dbit);
        int waited;
        waited = 0;
        @(posedge clk);
        rd_en   <= 1'b1;
        rd_addr <= addr;
        bypass  <= byp;
        @(posedge clk);
        rd_en <= 1'b0;
        @(negedge clk);
        while (!rd_valid) begin
            waited++;
            if (waited >= READ_TIMEOUT) begin
                $display("rd_valid did not rise within %0d cycles of a read", READ_TIMEOUT);
                abort_run();
            end
            @(negedge clk);
        end
        if (waited != 0) begin
            $display("rd_valid rose %0d cycles late for address 0x%0h", waited, addr);
            abort_run();
        end
        check_code("stored_check", i_dut.stored_check, exp_code);
        check_data("rd_data", rd_data, exp_data);
        check_flag("sbit_err", sbit_err, exp_sbit);
        check_flag("dbit_err", dbit_err, exp_dbit);
        if (exp_sbit) begin
            exp_sbit_count = exp_sbit_count + 1'b1;
        end
        if (exp_dbit) begin
            exp_dbit_count = exp_dbit_count + 1'b1;
        end
        if (exp_sbit || exp_dbit) begin
            exp_last_addr = addr;
        end
    endtask

    task automatic check_log_counts();
        @(posedge clk);     // the log updates at the edge that ends the valid cycle.
        @(negedge clk);
        check_count("sbit_count", sbit_count, exp_sbit_count);
        check_count("dbit_count", dbit_count, exp_dbit_count);
        check_addr("last_err_addr", last_err_addr, exp_last_addr);
    endtask

    task automatic test_clean_words();
        for (int a = 0; a < `ECC_MEM_DEPTH; a++) begin
            written[a] = random_word();
            write_word(ecc_addr_t'(a), written[a], '0, '0);
        end
        for (int a = 0; a < `ECC_MEM_DEPTH; a++) begin
            read_and_check(ecc_addr_t'(a), 1'b0, written[a], model_check(written[a]),
                           1'b0, 1'b0);
        end
    endtask

    task automatic test_single_data();
        ecc_addr_t addr;
        ecc_data_t data;
        ecc_data_t inj_d;
        repeat (NUM_SINGLE) begin
            addr  = random_addr();
            data  = random_word();
            inj_d = '0;
            inj_d[$urandom_range(`ECC_DATA_WIDTH - 1, 0)] = 1'b1;
            write_word(addr, data, inj_d, '0);
            read_and_check(addr, 1'b0, data, model_check(data), 1'b1, 1'b0);
        end
    endtask

    task automatic test_single_check();
        ecc_addr_t  addr;
        ecc_data_t  data;
        ecc_check_t inj_c;
        for (int b = 0; b < `ECC_CHECK_WIDTH; b++) begin
            addr     = random_addr();
            data     = random_word();
            inj_c    = '0;
            inj_c[b] = 1'b1;
            write_word(addr, data, '0, inj_c);
            read_and_check(addr, 1'b0, data, model_check(data) ^ inj_c, 1'b1, 1'b0);
        end
    endtask

    task automatic test_double_errors();
        ecc_addr_t  addr;
        ecc_data_t  data;
        ecc_data_t  inj_d;
        ecc_check_t inj_c;
        int         p1;
        repeat (NUM_DOUBLE) begin
            addr  = random_addr();
            data  = random_word();
            inj_d = '0;
            inj_c = '0;
            p1    = $urandom_range(FLIP_POSITIONS - 1, 0);
            add_flip(p1, inj_d, inj_c);
            add_flip(pick_other_position(p1), inj_d, inj_c);
            write_word(addr, data, inj_d, inj_c);
            read_and_check(addr, 1'b0, data ^ inj_d, model_check(data) ^ inj_c, 1'b0, 1'b1);
        end
    endtask

    task automatic test_bypass();
        ecc_addr_t  addr;
        ecc_data_t  data;
        ecc_data_t  inj_d;
        ecc_check_t inj_c;
        int         p1;
        for (int i = 0; i < NUM_BYPASS; i++) begin
            addr  = random_addr();
            data  = random_word();
            inj_d = '0;
            inj_c = '0;
            p1    = $urandom_range(FLIP_POSITIONS - 1, 0);
            add_flip(p1, inj_d, inj_c);
            if (i % 2 == 1) begin
                add_flip(pick_other_position(p1), inj_d, inj_c);  // every other word has two flips.
            end
            write_word(addr, data, inj_d, inj_c);
            read_and_check(addr, 1'b1, data ^ inj_d, model_check(data) ^ inj_c, 1'b0, 1'b0);
        end
        check_log_counts();
    endtask

    task automatic test_log_clear();
        @(posedge clk);
        log_clear <= 1'b1;
        @(posedge clk);
        log_clear <= 1'b0;
        exp_sbit_count = '0;
        exp_dbit_count = '0;
        exp_last_addr  = '0;
        check_log_counts();
    endtask

    initial begin
        #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles",
                 TEST_CYCLES + MARGIN_CYCLES);
        abort_run();
    end

    initial begin
        void'($urandom(26));
        reset        <= 1'b1;
        wr_en        <= 1'b0;
        wr_addr      <= '0;
        wr_data      <= '0;
        inject_data  <= '0;
        inject_check <= '0;
        rd_en        <= 1'b0;
        rd_addr      <= '0;
        bypass       <= 1'b0;
        log_clear    <= 1'b0;
        exp_sbit_count = '0;
        exp_dbit_count = '0;
        exp_last_addr  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_log_counts();
        check_flag("rd_valid", rd_valid, 1'b0);
        test_clean_words();
        test_single_data();
        test_single_check();
        test_double_errors();
        check_log_counts();
        test_bypass();
        test_log_clear();
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire
